//--- dcache.f
+incdir+design
design/dcache_pkg.sv
design/dcache_req_align.sv
design/dcache_line_store.sv
design/dcache_hit_ctrl.sv
design/dcache_miss_fsm.sv
design/dcache_top.sv
tests/wb_mem_model.sv
tests/dcache_tb.sv

//--- design/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address width seen by the load/store unit
`define DC_ADDR_W 32

// four 32-bit words per line
`define DC_LINE_BYTES 16

`define DC_SETS 64

// memory port moves one word per beat
`define DC_WB_W 32

`endif

//--- design/dcache_hit_ctrl.sv
`timescale 1ns/100ps

module dcache_hit_ctrl
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stage_valid_i,
    input  lookup_t                stage_i,
    input  logic [1:0][TAG_W-1:0]  tag_i,
    input  logic [1:0]             valid_i,
    input  logic [1:0]             dirty_i,
    input  logic [1:0][LINE_W-1:0] line_i,
    input  logic                   lru_i,
    input  logic                   miss_done_i,
    input  logic [LINE_W-1:0]      fill_line_i,
    output logic                   stall_o,
    output logic                   data_ok_o,
    output logic [31:0]            rdata_o,
    output logic                   hit_we_o,
    output logic                   hit_way_o,
    output logic [IDX_W-1:0]       hit_index_o,
    output logic [LINE_BYTES-1:0]  hit_be_o,
    output logic [LINE_W-1:0]      hit_line_o,
    output logic                   lru_we_o,
    output logic                   miss_start_o,
    output lookup_t                miss_req_o,
    output logic                   victim_way_o,
    output logic [TAG_W-1:0]       victim_tag_o,
    output logic                   victim_dirty_o,
    output logic [LINE_W-1:0]      victim_line_o
);

    logic              busy_q;
    logic              retire_q;
    logic              active;
    logic              is_store;
    logic [1:0]        hit_vec;
    logic              hit;
    logic [OFF_W-3:0]  word_sel;
    logic [LINE_W-1:0] resp_line;

    // the held entry is finished one cycle after a store hit or a refill
    assign active   = stage_valid_i & ~busy_q & ~retire_q;
    assign is_store = stage_i.req.op == OP_STORE;
    assign word_sel = stage_i.req.addr[OFF_W-1:2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = valid_i[w] && (tag_i[w] == stage_i.tag);
        end
    end

    assign hit = |hit_vec;

    assign hit_way_o   = hit_vec[1];
    assign hit_index_o = stage_i.index;
    assign hit_we_o    = active & hit & is_store;
    assign lru_we_o    = active & hit;
    assign hit_line_o  = {WORDS{stage_i.req.data}};

    // strobe placed on the addressed word of the line
    always_comb begin
        hit_be_o = '0;
        hit_be_o[word_sel*4 +: 4] = stage_i.req.strb;
    end

    assign resp_line = miss_done_i ? fill_line_i : line_i[hit_way_o];
    assign data_ok_o = (active & hit) | miss_done_i;
    assign rdata_o   = resp_line[word_sel*32 +: 32];

    assign miss_start_o   = active & ~hit;
    assign miss_req_o     = stage_i;
    assign victim_way_o   = lru_i;
    assign victim_tag_o   = tag_i[lru_i];
    assign victim_dirty_o = valid_i[lru_i] & dirty_i[lru_i];
    assign victim_line_o  = line_i[lru_i];

    assign stall_o = miss_start_o | hit_we_o | busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            retire_q <= 1'b0;
        end else begin
            retire_q <= hit_we_o | miss_done_i;
            if (miss_start_o) begin
                busy_q <= 1'b1;
            end else if (miss_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

//--- design/dcache_line_store.sv
`timescale 1ns/100ps

module dcache_line_store
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [IDX_W-1:0]       rd_index_i,
    output logic [1:0][TAG_W-1:0]  tag_o,
    output logic [1:0]             valid_o,
    output logic [1:0]             dirty_o,
    output logic [1:0][LINE_W-1:0] line_o,
    output logic                   lru_o,
    input  logic                   hit_we_i,
    input  logic                   hit_way_i,
    input  logic [IDX_W-1:0]       hit_index_i,
    input  logic [LINE_BYTES-1:0]  hit_be_i,
    input  logic [LINE_W-1:0]      hit_line_i,
    input  logic                   lru_we_i,
    input  logic                   fill_we_i,
    input  logic                   fill_way_i,
    input  logic [IDX_W-1:0]       fill_index_i,
    input  logic [TAG_W-1:0]       fill_tag_i,
    input  logic [LINE_W-1:0]      fill_line_i,
    input  logic                   fill_dirty_i
);

    logic [TAG_W-1:0]      tag_mem  [2][SETS];
    logic [LINE_W-1:0]     data_mem [2][SETS];
    logic [1:0][SETS-1:0]  valid_q;
    logic [1:0][SETS-1:0]  dirty_q;
    // points at the way to replace next
    logic [SETS-1:0]       lru_q;

    always_ff @(posedge clk) begin
        if (hit_we_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (hit_be_i[b]) begin
                    data_mem[hit_way_i][hit_index_i][8*b +: 8] <= hit_line_i[8*b +: 8];
                end
            end
        end
        if (fill_we_i) begin
            data_mem[fill_way_i][fill_index_i] <= fill_line_i;
            tag_mem[fill_way_i][fill_index_i]  <= fill_tag_i;
        end
        for (int w = 0; w < 2; w++) begin
            tag_o[w]  <= tag_mem[w][rd_index_i];
            line_o[w] <= data_mem[w][rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            valid_o <= '0;
            dirty_o <= '0;
            lru_o   <= 1'b0;
        end else begin
            if (hit_we_i) begin
                dirty_q[hit_way_i][hit_index_i] <= 1'b1;
            end
            if (lru_we_i) begin
                lru_q[hit_index_i] <= ~hit_way_i;
            end
            // a filled way becomes the most recently used one
            if (fill_we_i) begin
                valid_q[fill_way_i][fill_index_i] <= 1'b1;
                dirty_q[fill_way_i][fill_index_i] <= fill_dirty_i;
                lru_q[fill_index_i]               <= ~fill_way_i;
            end
            valid_o <= {valid_q[1][rd_index_i], valid_q[0][rd_index_i]};
            dirty_o <= {dirty_q[1][rd_index_i], dirty_q[0][rd_index_i]};
            lru_o   <= lru_q[rd_index_i];
        end
    end

endmodule

//--- design/dcache_miss_fsm.sv
`timescale 1ns/100ps

module dcache_miss_fsm
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              miss_start_i,
    input  lookup_t           miss_req_i,
    input  logic              victim_way_i,
    input  logic [TAG_W-1:0]  victim_tag_i,
    input  logic              victim_dirty_i,
    input  logic [LINE_W-1:0] victim_line_i,
    output wb_req_t           wb_o,
    input  wb_rsp_t           wb_i,
    output logic              fill_we_o,
    output logic              fill_way_o,
    output logic [IDX_W-1:0]  fill_index_o,
    output logic [TAG_W-1:0]  fill_tag_o,
    output logic              fill_dirty_o,
    output logic              miss_done_o,
    output logic [LINE_W-1:0] fill_line_o
);

    miss_state_e       state_q;
    logic [OFF_W-3:0]  beat_q;
    lookup_t           req_q;
    logic              way_q;
    logic [TAG_W-1:0]  vtag_q;
    logic [LINE_W-1:0] vline_q;
    logic [LINE_W-1:0] buf_q;
    logic              writing;
    logic              beat_ack;
    logic              store_word;
    logic [WB_W-1:0]   rd_word;

    assign writing    = state_q == MS_WB_BEAT;
    assign beat_ack   = wb_o.stb & wb_i.ack;
    assign store_word = (req_q.req.op == OP_STORE) && (beat_q == req_q.req.addr[OFF_W-1:2]);

    // pending store bytes replace the refilled word as it arrives
    always_comb begin
        rd_word = wb_i.dat;
        if (store_word) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.req.strb[b]) begin
                    rd_word[8*b +: 8] = req_q.req.data[8*b +: 8];
                end
            end
        end
    end

    // stb drops after every ack, cyc only after the last beat of a line
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MS_IDLE;
            beat_q  <= '0;
            wb_o    <= '0;
        end else begin
            case (state_q)
                MS_IDLE: begin
                    if (miss_start_i) begin
                        state_q <= victim_dirty_i ? MS_WB_BEAT : MS_RD_BEAT;
                        beat_q  <= '0;
                    end
                end
                MS_WB_BEAT, MS_RD_BEAT: begin
                    if (!wb_o.stb) begin
                        wb_o.cyc <= 1'b1;
                        wb_o.stb <= 1'b1;
                        wb_o.we  <= writing;
                        wb_o.sel <= 4'hf;
                        wb_o.adr <= {writing ? vtag_q : req_q.tag, req_q.index, beat_q};
                        wb_o.dat <= writing ? vline_q[beat_q*WB_W +: WB_W] : '0;
                    end else if (wb_i.ack) begin
                        wb_o.stb <= 1'b0;
                        beat_q   <= beat_q + 1'b1;
                        if (beat_q == '1) begin
                            wb_o.cyc <= 1'b0;
                            state_q  <= writing ? MS_RD_BEAT : MS_FILL;
                        end
                    end
                end
                MS_FILL: begin
                    state_q <= MS_DONE;
                end
                default: begin
                    state_q <= MS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MS_IDLE && miss_start_i) begin
            req_q   <= miss_req_i;
            way_q   <= victim_way_i;
            vtag_q  <= victim_tag_i;
            vline_q <= victim_line_i;
        end
        if (state_q == MS_RD_BEAT && beat_ack) begin
            buf_q[beat_q*WB_W +: WB_W] <= rd_word;
        end
    end

    // the refilled line replaces the victim way
    assign fill_we_o    = state_q == MS_FILL;
    assign fill_way_o   = way_q;
    assign fill_index_o = req_q.index;
    assign fill_tag_o   = req_q.tag;
    assign fill_dirty_o = req_q.req.op == OP_STORE;
    assign fill_line_o  = buf_q;
    assign miss_done_o  = state_q == MS_DONE;

endmodule

//--- design/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    localparam int ADDR_W     = `DC_ADDR_W;
    localparam int LINE_BYTES = `DC_LINE_BYTES;
    localparam int SETS       = `DC_SETS;
    localparam int WB_W       = `DC_WB_W;
    localparam int OFF_W      = $clog2(LINE_BYTES);
    localparam int IDX_W      = $clog2(SETS);
    localparam int TAG_W      = ADDR_W - IDX_W - OFF_W;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int WORDS      = LINE_BYTES / 4;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [3:0]        strb;
        logic [31:0]       data;
    } cpu_req_t;

    // request plus its address split, stage 1 to stage 2
    typedef struct packed {
        cpu_req_t         req;
        logic [IDX_W-1:0] index;
        logic [TAG_W-1:0] tag;
    } lookup_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_WB_BEAT,
        MS_RD_BEAT,
        MS_FILL,
        MS_DONE
    } miss_state_e;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;
        logic [ADDR_W-3:0] adr;
        logic [WB_W-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [WB_W-1:0] dat;
    } wb_rsp_t;

endpackage

//--- design/dcache_req_align.sv
`timescale 1ns/100ps

module dcache_req_align
    import dcache_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid_i,
    input  cpu_req_t         req_i,
    input  logic             stall_i,
    output logic             ready_o,
    output logic [IDX_W-1:0] rd_index_o,
    output logic             stage_valid_o,
    output lookup_t          stage_o
);

    logic             accept;
    logic [IDX_W-1:0] req_index;
    logic [TAG_W-1:0] req_tag;

    assign ready_o = ~stall_i;
    assign accept  = req_valid_i & ready_o;

    // offset bits stay inside the request address
    assign req_index = req_i.addr[OFF_W +: IDX_W];
    assign req_tag   = req_i.addr[ADDR_W-1 -: TAG_W];

    // without a new request the arrays keep re-reading the waiting entry
    assign rd_index_o = accept ? req_index : stage_o.index;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid_o <= 1'b0;
        end else if (!stall_i) begin
            stage_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_o.req   <= req_i;
            stage_o.index <= req_index;
            stage_o.tag   <= req_tag;
        end
    end

endmodule

//--- design/dcache_top.sv
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid_i,
    input  cpu_req_t    req_i,
    output logic        ready_o,
    output logic        data_ok_o,
    output logic [31:0] rdata_o,
    output wb_req_t     wb_o,
    input  wb_rsp_t     wb_i
);

    logic                        stall;
    logic [IDX_W-1:0]            rd_index;
    logic                        stage_valid;
    lookup_t                     stage;

    logic [1:0][TAG_W-1:0]       arr_tag;
    logic [1:0]                  arr_valid;
    logic [1:0]                  arr_dirty;
    logic [1:0][LINE_W-1:0]      arr_line;
    logic                        arr_lru;

    logic                        hit_we;
    logic                        hit_way;
    logic [IDX_W-1:0]            hit_index;
    logic [LINE_BYTES-1:0]       hit_be;
    logic [LINE_W-1:0]           hit_line;
    logic                        lru_we;

    logic                        miss_start;
    lookup_t                     miss_req;
    logic                        victim_way;
    logic [TAG_W-1:0]            victim_tag;
    logic                        victim_dirty;
    logic [LINE_W-1:0]           victim_line;

    logic                        fill_we;
    logic                        fill_way;
    logic [IDX_W-1:0]            fill_index;
    logic [TAG_W-1:0]            fill_tag;
    logic                        fill_dirty;
    logic [LINE_W-1:0]           fill_line;
    logic                        miss_done;

    dcache_req_align u_req_align (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .stall_i      (stall),
        .ready_o      (ready_o),
        .rd_index_o   (rd_index),
        .stage_valid_o(stage_valid),
        .stage_o      (stage)
    );

    dcache_line_store u_line_store (
        .clk         (clk),
        .rst         (rst),
        .rd_index_i  (rd_index),
        .tag_o       (arr_tag),
        .valid_o     (arr_valid),
        .dirty_o     (arr_dirty),
        .line_o      (arr_line),
        .lru_o       (arr_lru),
        .hit_we_i    (hit_we),
        .hit_way_i   (hit_way),
        .hit_index_i (hit_index),
        .hit_be_i    (hit_be),
        .hit_line_i  (hit_line),
        .lru_we_i    (lru_we),
        .fill_we_i   (fill_we),
        .fill_way_i  (fill_way),
        .fill_index_i(fill_index),
        .fill_tag_i  (fill_tag),
        .fill_line_i (fill_line),
        .fill_dirty_i(fill_dirty)
    );

    dcache_hit_ctrl u_hit_ctrl (
        .clk           (clk),
        .rst           (rst),
        .stage_valid_i (stage_valid),
        .stage_i       (stage),
        .tag_i         (arr_tag),
        .valid_i       (arr_valid),
        .dirty_i       (arr_dirty),
        .line_i        (arr_line),
        .lru_i         (arr_lru),
        .miss_done_i   (miss_done),
        .fill_line_i   (fill_line),
        .stall_o       (stall),
        .data_ok_o     (data_ok_o),
        .rdata_o       (rdata_o),
        .hit_we_o      (hit_we),
        .hit_way_o     (hit_way),
        .hit_index_o   (hit_index),
        .hit_be_o      (hit_be),
        .hit_line_o    (hit_line),
        .lru_we_o      (lru_we),
        .miss_start_o  (miss_start),
        .miss_req_o    (miss_req),
        .victim_way_o  (victim_way),
        .victim_tag_o  (victim_tag),
        .victim_dirty_o(victim_dirty),
        .victim_line_o (victim_line)
    );

    dcache_miss_fsm u_miss_fsm (
        .clk           (clk),
        .rst           (rst),
        .miss_start_i  (miss_start),
        .miss_req_i    (miss_req),
        .victim_way_i  (victim_way),
        .victim_tag_i  (victim_tag),
        .victim_dirty_i(victim_dirty),
        .victim_line_i (victim_line),
        .wb_o          (wb_o),
        .wb_i          (wb_i),
        .fill_we_o     (fill_we),
        .fill_way_o    (fill_way),
        .fill_index_o  (fill_index),
        .fill_tag_o    (fill_tag),
        .fill_dirty_o  (fill_dirty),
        .miss_done_o   (miss_done),
        .fill_line_o   (fill_line)
    );

endmodule

//--- tests/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int MAX_ENT   = 48;
    localparam int MEM_WORDS = 4096;
    localparam int LIMIT     = 300;

    logic        clk;
    logic        rst;
    logic        req_valid;
    cpu_req_t    req;
    logic        ready;
    logic        data_ok;
    logic [31:0] rdata;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    // stimulus table, one row per request
    int          ent_test [MAX_ENT];
    mem_op_e     ent_op   [MAX_ENT];
    logic [31:0] ent_addr [MAX_ENT];
    logic [3:0]  ent_strb [MAX_ENT];
    logic [31:0] ent_data [MAX_ENT];
    logic [31:0] ent_exp  [MAX_ENT];
    int          n_ent;

    logic [31:0] shadow [MEM_WORDS];
    string       test_name [1:5];
    int          pending [$];
    int          resp_entry;
    int          idle_cycles;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          failed_tests;
    bit          aborted;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    dcache_top dcache_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid),
        .req_i      (req),
        .ready_o    (ready),
        .data_ok_o  (data_ok),
        .rdata_o    (rdata),
        .wb_o       (wb_req),
        .wb_i       (wb_rsp)
    );

    wb_mem_model u_mem (
        .clk     (clk),
        .rst     (rst),
        .wb_req_i(wb_req),
        .wb_rsp_o(wb_rsp)
    );

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic add_entry(input int t, input mem_op_e op, input logic [31:0] addr,
                             input logic [3:0] strb, input logic [31:0] data);
        ent_test[n_ent] = t;
        ent_op[n_ent]   = op;
        ent_addr[n_ent] = addr;
        ent_strb[n_ent] = strb;
        ent_data[n_ent] = data;
        n_ent++;
    endtask

    task automatic build_table();
        test_name[1] = "reset state";
        test_name[2] = "load miss then hit";
        test_name[3] = "store merge";
        test_name[4] = "dirty eviction";
        test_name[5] = "load burst";
        add_entry(2, OP_LOAD,  32'h104, 4'h0, 32'h0);
        add_entry(2, OP_LOAD,  32'h104, 4'h0, 32'h0);
        add_entry(2, OP_LOAD,  32'h10c, 4'h0, 32'h0);
        add_entry(3, OP_STORE, 32'h108, 4'hf, 32'hcafe_f00d);
        add_entry(3, OP_LOAD,  32'h108, 4'h0, 32'h0);
        // store miss with a single byte
        add_entry(3, OP_STORE, 32'h200, 4'h2, 32'h1122_3344);
        add_entry(3, OP_LOAD,  32'h200, 4'h0, 32'h0);
        add_entry(3, OP_STORE, 32'h204, 4'hc, 32'hbeef_0000);
        add_entry(3, OP_LOAD,  32'h204, 4'h0, 32'h0);
        add_entry(3, OP_STORE, 32'h20c, 4'h8, 32'h7700_0000);
        add_entry(3, OP_STORE, 32'h310, 4'h3, 32'h0000_abcd);
        add_entry(3, OP_LOAD,  32'h20c, 4'h0, 32'h0);
        add_entry(3, OP_LOAD,  32'h310, 4'h0, 32'h0);
        add_entry(3, OP_LOAD,  32'h314, 4'h0, 32'h0);
        // four lines of set 5 through two ways
        add_entry(4, OP_STORE, 32'h050, 4'hf, 32'h0a0a_0050);
        add_entry(4, OP_STORE, 32'h454, 4'hf, 32'h0b0b_0454);
        add_entry(4, OP_STORE, 32'h858, 4'hf, 32'h0c0c_0858);
        add_entry(4, OP_STORE, 32'hc5c, 4'h3, 32'h0000_0c5c);
        add_entry(4, OP_LOAD,  32'h050, 4'h0, 32'h0);
        add_entry(4, OP_LOAD,  32'h454, 4'h0, 32'h0);
        add_entry(4, OP_LOAD,  32'h858, 4'h0, 32'h0);
        add_entry(4, OP_LOAD,  32'hc5c, 4'h0, 32'h0);
        add_entry(4, OP_LOAD,  32'h458, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h100, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h104, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h108, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h10c, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h200, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h204, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h20c, 4'h0, 32'h0);
        add_entry(5, OP_LOAD,  32'h310, 4'h0, 32'h0);
    endtask

    // walks the table in order against a flat memory image
    task automatic compute_expected();
        int widx;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = i ^ 32'h5a5a_0000;
        end
        for (int e = 0; e < n_ent; e++) begin
            widx = ent_addr[e][13:2];
            if (ent_op[e] == OP_STORE) begin
                for (int b = 0; b < 4; b++) begin
                    if (ent_strb[e][b]) begin
                        shadow[widx][8*b +: 8] = ent_data[e][8*b +: 8];
                    end
                end
            end
            ent_exp[e] = shadow[widx];
        end
    endtask

    task automatic check_idle();
        assert (ready === 1'b1) else begin
            $display("error: %0t ready_o expected 1 got %b", $time, ready);
            note_error();
        end
        assert (data_ok === 1'b0) else begin
            $display("error: %0t data_ok_o expected 0 got %b", $time, data_ok);
            note_error();
        end
        assert (wb_req.cyc === 1'b0) else begin
            $display("error: %0t wb_o.cyc expected 0 got %b", $time, wb_req.cyc);
            note_error();
        end
        assert (wb_req.stb === 1'b0) else begin
            $display("error: %0t wb_o.stb expected 0 got %b", $time, wb_req.stb);
            note_error();
        end
    endtask

    // called on a rising edge, returns on the edge that accepted the request
    task automatic apply_entry(input int e);
        int waited;
        waited = 0;
        req_valid <= 1'b1;
        req.op    <= ent_op[e];
        req.addr  <= ent_addr[e];
        req.strb  <= ent_strb[e];
        req.data  <= ent_data[e];
        @(negedge clk);
        while (ready !== 1'b1 && waited < LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (ready !== 1'b1) begin
            $display("timeout: ready_o stayed low for %0d cycles at %0t", LIMIT, $time);
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            pending.push_back(e);
        end
    endtask

    task automatic drain_pending();
        int waited;
        waited = 0;
        while (pending.size() > 0 && waited < LIMIT && !aborted) begin
            waited++;
            @(posedge clk);
        end
        if (pending.size() > 0 && !aborted) begin
            $display("timeout: %0d responses missing at %0t", pending.size(), $time);
            aborted = 1'b1;
        end
    endtask

    task automatic report_test(input int t);
        tests_run++;
        if (test_errors == 0 && !aborted) begin
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("test %0d %s: failed, %0d errors", t, test_name[t], test_errors);
            failed_tests++;
        end
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        test_errors = 0;
        for (int e = 0; e < n_ent; e++) begin
            if (ent_test[e] == t && !aborted) begin
                apply_entry(e);
            end
        end
        req_valid <= 1'b0;
        drain_pending();
        report_test(t);
    endtask

    // pairs every response with the oldest accepted request
    always @(negedge clk) begin
        if (rst || pending.size() == 0) begin
            idle_cycles = 0;
        end
        if (!rst && data_ok === 1'b1) begin
            idle_cycles = 0;
            assert (pending.size() > 0) else begin
                $display("data_ok_o pulsed at %0t with no request outstanding", $time);
                note_error();
            end
            if (pending.size() > 0) begin
                resp_entry = pending.pop_front();
                if (ent_op[resp_entry] == OP_LOAD) begin
                    assert (rdata === ent_exp[resp_entry]) else begin
                        $display("error: %0t rdata_o at %h expected %h got %h", $time,
                                 ent_addr[resp_entry], ent_exp[resp_entry], rdata);
                        note_error();
                    end
                end
            end
        end else if (pending.size() > 0) begin
            idle_cycles++;
            if (idle_cycles == LIMIT && !aborted) begin
                $display("timeout: no data_ok_o for %0d cycles at %0t", LIMIT, $time);
                aborted = 1'b1;
            end
        end
    end

    initial begin
        rst          <= 1'b1;
        req_valid    <= 1'b0;
        req          <= '0;
        n_ent        = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        failed_tests = 0;
        aborted      = 1'b0;
        build_table();
        compute_expected();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle();
        report_test(1);
        for (int t = 2; t <= 5; t++) begin
            if (!aborted) begin
                run_test(t);
            end
        end
        $display("tests: %0d run, %0d failed, %0d errors", tests_run, failed_tests, errors);
        if (errors == 0 && failed_tests == 0 && !aborted) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tests/wb_mem_model.sv
`timescale 1ns/100ps

module wb_mem_model
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    // covers the first 16 KB of the address space
    localparam int DEPTH = 4096;

    logic [31:0] mem [DEPTH];
    integer      seed;
    logic        waiting_q;
    logic [1:0]  wait_q;
    logic [1:0]  delay;
    logic [11:0] word;

    assign word = wb_req_i.adr[11:0];

    initial begin
        seed = 32'h8792_1071;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= i ^ 32'h5a5a_0000;
        end
    end

    // ack is registered, so even a zero delay answers one cycle after stb
    always @(posedge clk) begin
        if (rst) begin
            wb_rsp_o  <= '0;
            waiting_q <= 1'b0;
            wait_q    <= '0;
        end else if (wb_rsp_o.ack) begin
            wb_rsp_o.ack <= 1'b0;
        end else if (wb_req_i.cyc && wb_req_i.stb) begin
            delay = waiting_q ? wait_q : 2'($random(seed));
            if (delay == 2'd0) begin
                wb_rsp_o.ack <= 1'b1;
                wb_rsp_o.dat <= mem[word];
                waiting_q    <= 1'b0;
                if (wb_req_i.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req_i.sel[b]) begin
                            mem[word][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                        end
                    end
                end
            end else begin
                waiting_q <= 1'b1;
                wait_q    <= delay - 1'b1;
            end
        end
    end

endmodule
